/* rtl/wb_pkg.sv */
package wb_pkg;

  // Core side data, instructions and byte addresses
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // Bus word address and byte-lane selects
  typedef logic [29:0] wb_adr_t;
  typedef logic [3:0]  wb_sel_t;

  // Access size code from the core
  typedef logic [1:0]  size_t;

  // Size codes, the spare code 3 is handled as a byte
  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;

  // Memory map, a single RAM at RAM_BASE
  localparam int      RAM_WORDS     = 256;
  localparam int      RAM_IDX_W     = $clog2(RAM_WORDS);
  localparam addr_t   RAM_BASE      = 32'h0000_0000;
  localparam wb_adr_t RAM_BASE_WORD = RAM_BASE[31:2];

  // Master to slave side of a classic cycle
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_sel_t sel;
    word_t   dat;
  } wb_req_t;

  // Slave to master side, ack and err are mutually exclusive
  typedef struct packed {
    logic  ack;
    logic  err;
    word_t dat;
  } wb_rsp_t;

  // Shared by both bus masters
  typedef enum logic {
    BUS_IDLE,
    BUS_WAIT
  } master_state_t;

  // Current bus owner
  typedef enum logic {
    GRANT_LSU,
    GRANT_FETCH
  } grant_t;

endpackage

/* rtl/wb_lsu_master.sv */
`timescale 1ns/1ps

module wb_lsu_master (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             clear_i,
  input  logic             data_req_i,
  input  wb_pkg::addr_t    data_addr_i,
  input  wb_pkg::word_t    data_wdata_i,
  input  wb_pkg::size_t    data_size_i,
  input  logic             data_write_i,
  output wb_pkg::word_t    data_rdata_o,
  output logic             data_busy_o,
  output logic             data_err_o,
  output wb_pkg::wb_req_t  bus_req_o,
  input  wb_pkg::wb_rsp_t  bus_rsp_i
);
  import wb_pkg::*;

  master_state_t state_q;
  logic          accept;
  logic          err_q;

  // Latched cycle payload
  wb_adr_t adr_q;
  wb_sel_t sel_q;
  word_t   wdat_q;
  logic    we_q;
  logic [1:0] off_q;
  size_t   size_q;
  word_t   rdata_q;

  // Request decode, low bits below the access size are ignored
  logic [1:0] req_off;
  wb_sel_t    req_sel;
  word_t      req_wdat;

  // Read path alignment
  word_t rd_shifted;
  word_t rd_aligned;

  assign accept = data_req_i && (state_q == BUS_IDLE);

  always_comb begin
    case (data_size_i)
      SIZE_HALF: begin
        req_off  = {data_addr_i[1], 1'b0};
        req_sel  = data_addr_i[1] ? 4'b1100 : 4'b0011;
        // Half-word copied into both lane pairs
        req_wdat = {2{data_wdata_i[15:0]}};
      end
      SIZE_WORD: begin
        req_off  = 2'b00;
        req_sel  = 4'b1111;
        req_wdat = data_wdata_i;
      end
      default: begin
        // Byte, also taken for the unused size code
        req_off  = data_addr_i[1:0];
        req_sel  = 4'b0001 << data_addr_i[1:0];
        req_wdat = {4{data_wdata_i[7:0]}};
      end
    endcase
  end

  // Move the addressed lanes down to bit 0
  assign rd_shifted = bus_rsp_i.dat >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      SIZE_HALF: rd_aligned = {16'h0000, rd_shifted[15:0]};
      SIZE_WORD: rd_aligned = rd_shifted;
      default:   rd_aligned = {24'h00_0000, rd_shifted[7:0]};
    endcase
  end

  // Control state
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BUS_IDLE;
      err_q   <= 1'b0;
    end else if (clear_i) begin
      // Flush drops the cycle and the sticky error
      state_q <= BUS_IDLE;
      err_q   <= 1'b0;
    end else if (accept) begin
      state_q <= BUS_WAIT;
      err_q   <= 1'b0;
    end else if (state_q == BUS_WAIT) begin
      if (bus_rsp_i.ack) begin
        state_q <= BUS_IDLE;
      end else if (bus_rsp_i.err) begin
        state_q <= BUS_IDLE;
        err_q   <= 1'b1;
      end
    end
  end

  // Payload captured on accept, read data on ack
  always_ff @(posedge clk_i) begin
    if (accept) begin
      adr_q  <= data_addr_i[31:2];
      off_q  <= req_off;
      size_q <= data_size_i;
      sel_q  <= req_sel;
      wdat_q <= req_wdat;
      we_q   <= data_write_i;
    end
    if ((state_q == BUS_WAIT) && bus_rsp_i.ack) begin
      rdata_q <= rd_aligned;
    end
  end

  // cyc and stb follow the wait state, we only inside a cycle
  assign bus_req_o.cyc = (state_q == BUS_WAIT);
  assign bus_req_o.stb = (state_q == BUS_WAIT);
  assign bus_req_o.we  = (state_q == BUS_WAIT) && we_q;
  assign bus_req_o.adr = adr_q;
  assign bus_req_o.sel = sel_q;
  assign bus_req_o.dat = wdat_q;

  assign data_rdata_o = rdata_q;
  assign data_busy_o  = (state_q == BUS_WAIT);
  assign data_err_o   = err_q;

endmodule

/* rtl/wb_fetch_master.sv */
`timescale 1ns/1ps

module wb_fetch_master (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             clear_i,
  input  logic             fetch_req_i,
  input  wb_pkg::addr_t    fetch_pc_i,
  output wb_pkg::word_t    fetch_instr_o,
  output logic             fetch_valid_o,
  output logic             fetch_err_o,
  output logic             fetch_busy_o,
  output wb_pkg::wb_req_t  bus_req_o,
  input  wb_pkg::wb_rsp_t  bus_rsp_i
);
  import wb_pkg::*;

  master_state_t state_q;
  logic          valid_q;
  logic          err_q;
  logic          accept;
  logic          done;

  wb_adr_t adr_q;
  word_t   instr_q;

  assign accept = fetch_req_i && (state_q == BUS_IDLE);
  // Cycle ends on either response
  assign done   = (state_q == BUS_WAIT) && (bus_rsp_i.ack || bus_rsp_i.err);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BUS_IDLE;
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      // Status outputs are single-cycle pulses
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      if (clear_i) begin
        state_q <= BUS_IDLE;
      end else if (accept) begin
        state_q <= BUS_WAIT;
      end else if (done) begin
        state_q <= BUS_IDLE;
        valid_q <= bus_rsp_i.ack;
        err_q   <= bus_rsp_i.err;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      adr_q <= fetch_pc_i[31:2];
    end
    if ((state_q == BUS_WAIT) && bus_rsp_i.ack) begin
      instr_q <= bus_rsp_i.dat;
    end
  end

  // Read-only master, always a full word
  assign bus_req_o.cyc = (state_q == BUS_WAIT);
  assign bus_req_o.stb = (state_q == BUS_WAIT);
  assign bus_req_o.we  = 1'b0;
  assign bus_req_o.adr = adr_q;
  assign bus_req_o.sel = 4'b1111;
  assign bus_req_o.dat = '0;

  assign fetch_instr_o = instr_q;
  assign fetch_valid_o = valid_q;
  assign fetch_err_o   = err_q;
  assign fetch_busy_o  = (state_q == BUS_WAIT);

endmodule

/* rtl/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  wb_pkg::wb_req_t  lsu_req_i,
  input  wb_pkg::wb_req_t  fetch_req_i,
  output wb_pkg::wb_rsp_t  lsu_rsp_o,
  output wb_pkg::wb_rsp_t  fetch_rsp_o,
  output wb_pkg::wb_req_t  bus_req_o,
  input  wb_pkg::wb_rsp_t  bus_rsp_i
);
  import wb_pkg::*;

  grant_t grant_q;
  // cyc of whichever master holds the grant
  logic   owner_cyc;

  assign owner_cyc = (grant_q == GRANT_LSU) ? lsu_req_i.cyc : fetch_req_i.cyc;

  // Grant only moves while the owner is off the bus
  // Load/store wins a tie, otherwise the grant stays parked
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      grant_q <= GRANT_LSU;
    end else if (!owner_cyc) begin
      if (lsu_req_i.cyc) begin
        grant_q <= GRANT_LSU;
      end else if (fetch_req_i.cyc) begin
        grant_q <= GRANT_FETCH;
      end
    end
  end

  // Request mux and response steering
  always_comb begin
    lsu_rsp_o   = '0;
    fetch_rsp_o = '0;
    if (grant_q == GRANT_LSU) begin
      bus_req_o = lsu_req_i;
      lsu_rsp_o = bus_rsp_i;
    end else begin
      bus_req_o   = fetch_req_i;
      fetch_rsp_o = bus_rsp_i;
    end
  end

endmodule

/* rtl/wb_addr_decoder.sv */
`timescale 1ns/1ps

module wb_addr_decoder (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  wb_pkg::wb_req_t  bus_req_i,
  output wb_pkg::wb_rsp_t  bus_rsp_o,
  output wb_pkg::wb_req_t  ram_req_o,
  input  wb_pkg::wb_rsp_t  ram_rsp_i
);
  import wb_pkg::*;

  // Word offset from the RAM base, wraps high below the base
  wb_adr_t rel_adr;
  logic    in_range;
  logic    err_q;

  assign rel_adr  = bus_req_i.adr - RAM_BASE_WORD;
  assign in_range = (rel_adr < wb_adr_t'(RAM_WORDS));

  // RAM only sees cycles that fall inside its window
  always_comb begin
    ram_req_o     = bus_req_i;
    ram_req_o.cyc = bus_req_i.cyc && in_range;
    ram_req_o.stb = bus_req_i.stb && in_range;
  end

  // Own error response for unmapped cycles, one cycle wide
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus_req_i.stb && !in_range && !err_q;
    end
  end

  // Merge RAM response with the local error
  assign bus_rsp_o.ack = ram_rsp_i.ack;
  assign bus_rsp_o.err = err_q;
  assign bus_rsp_o.dat = ram_rsp_i.dat;

endmodule

/* rtl/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  wb_pkg::wb_req_t  bus_req_i,
  output wb_pkg::wb_rsp_t  bus_rsp_o
);
  import wb_pkg::*;

  word_t mem [RAM_WORDS];

  logic                 ack_q;
  word_t                rdat_q;
  logic [RAM_IDX_W-1:0] idx;
  // New access when strobed and no ack outstanding
  logic                 hit;

  assign idx = bus_req_i.adr[RAM_IDX_W-1:0];
  assign hit = bus_req_i.stb && !ack_q;

  // Ack rises once per strobe, drops when stb goes away
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
    end
  end

  // Lane writes land on the same edge as the ack
  always_ff @(posedge clk_i) begin
    if (hit) begin
      if (bus_req_i.we) begin
        for (int lane = 0; lane < 4; lane++) begin
          if (bus_req_i.sel[lane]) begin
            mem[idx][lane*8 +: 8] <= bus_req_i.dat[lane*8 +: 8];
          end
        end
      end
      // Old contents, only used on reads
      rdat_q <= mem[idx];
    end
  end

  assign bus_rsp_o.ack = ack_q;
  // RAM never signals an error
  assign bus_rsp_o.err = 1'b0;
  assign bus_rsp_o.dat = rdat_q;

endmodule

/* rtl/wb_mem_subsystem.sv */
`timescale 1ns/1ps

module wb_mem_subsystem (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           clear_i,
  input  logic           data_req_i,
  input  wb_pkg::addr_t  data_addr_i,
  input  wb_pkg::word_t  data_wdata_i,
  input  wb_pkg::size_t  data_size_i,
  input  logic           data_write_i,
  output wb_pkg::word_t  data_rdata_o,
  output logic           data_busy_o,
  output logic           data_err_o,
  input  logic           fetch_req_i,
  input  wb_pkg::addr_t  fetch_pc_i,
  output wb_pkg::word_t  fetch_instr_o,
  output logic           fetch_valid_o,
  output logic           fetch_err_o,
  output logic           fetch_busy_o
);
  import wb_pkg::*;

  // Master side
  wb_req_t lsu_req;
  wb_req_t fetch_req;
  wb_rsp_t lsu_rsp;
  wb_rsp_t fetch_rsp;

  // Shared bus and RAM port
  wb_req_t bus_req;
  wb_rsp_t bus_rsp;
  wb_req_t ram_req;
  wb_rsp_t ram_rsp;

  wb_lsu_master u_lsu (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .clear_i      (clear_i),
    .data_req_i   (data_req_i),
    .data_addr_i  (data_addr_i),
    .data_wdata_i (data_wdata_i),
    .data_size_i  (data_size_i),
    .data_write_i (data_write_i),
    .data_rdata_o (data_rdata_o),
    .data_busy_o  (data_busy_o),
    .data_err_o   (data_err_o),
    .bus_req_o    (lsu_req),
    .bus_rsp_i    (lsu_rsp)
  );

  wb_fetch_master u_fetch (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .clear_i       (clear_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_instr_o (fetch_instr_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_err_o   (fetch_err_o),
    .fetch_busy_o  (fetch_busy_o),
    .bus_req_o     (fetch_req),
    .bus_rsp_i     (fetch_rsp)
  );

  wb_arbiter u_arb (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .lsu_req_i   (lsu_req),
    .fetch_req_i (fetch_req),
    .lsu_rsp_o   (lsu_rsp),
    .fetch_rsp_o (fetch_rsp),
    .bus_req_o   (bus_req),
    .bus_rsp_i   (bus_rsp)
  );

  wb_addr_decoder u_dec (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .ram_req_o (ram_req),
    .ram_rsp_i (ram_rsp)
  );

  wb_ram u_ram (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .bus_req_i (ram_req),
    .bus_rsp_o (ram_rsp)
  );

endmodule

/* test/wb_clock_gen.sv */
`timescale 1ns/1ps

module wb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset low for two rising edges, released away from the edge
  initial begin
    arst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* test/wb_mem_subsystem_props.sv */
`timescale 1ns/1ps

module wb_mem_subsystem_props (
  input logic             clk_i,
  input logic             arst_n_i,
  input wb_pkg::wb_req_t  lsu_req_i,
  input wb_pkg::wb_req_t  fetch_req_i,
  input wb_pkg::wb_rsp_t  lsu_rsp_i,
  input wb_pkg::wb_rsp_t  fetch_rsp_i,
  input wb_pkg::wb_req_t  bus_req_i,
  input wb_pkg::wb_rsp_t  bus_rsp_i,
  input wb_pkg::grant_t   grant_i
);
  import wb_pkg::*;

  // cyc of the current bus owner
  logic owner_cyc;

  assign owner_cyc = (grant_i == GRANT_LSU) ? lsu_req_i.cyc : fetch_req_i.cyc;

  stb_within_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus_req_i.stb |-> bus_req_i.cyc)
    else $error("Bus stb high without cyc");

  ack_err_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(bus_rsp_i.ack && bus_rsp_i.err))
    else $error("Bus ack and err high together");

  // The master without the grant only ever sees an idle response
  rsp_to_owner_only: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (grant_i == GRANT_LSU) ? (fetch_rsp_i == '0) : (lsu_rsp_i == '0))
    else $error("Response leaked to the master without the grant");

  grant_held_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    owner_cyc |=> $stable(grant_i))
    else $error("Grant moved while the owner held cyc");

  // Both masters off the bus and grant on load/store as reset lifts
  reset_state: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !lsu_req_i.cyc && !fetch_req_i.cyc && (grant_i == GRANT_LSU))
    else $error("Bus not idle after reset");

endmodule

bind wb_arbiter wb_mem_subsystem_props u_props (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .lsu_req_i   (lsu_req_i),
  .fetch_req_i (fetch_req_i),
  .lsu_rsp_i   (lsu_rsp_o),
  .fetch_rsp_i (fetch_rsp_o),
  .bus_req_i   (bus_req_o),
  .bus_rsp_i   (bus_rsp_i),
  .grant_i     (grant_q)
);

/* test/wb_mem_subsystem_tb.sv */
`timescale 1ns/1ps

module wb_mem_subsystem_tb;
  import wb_pkg::*;

  // About 300 accesses of 4 to 8 cycles each with ample margin
  localparam int MAX_CYCLES = 3000;
  // Cycles allowed per access including a wait behind the other master
  localparam int WAIT_LIMIT = 20;
  // Preloaded words that also bound the random test
  localparam int WINDOW_WORDS = 32;
  localparam addr_t MAP_END = RAM_BASE + 4 * RAM_WORDS;

  // DUT inputs and outputs
  logic  clk_i;
  logic  arst_n_i;
  logic  clear_i;
  logic  data_req_i;
  addr_t data_addr_i;
  word_t data_wdata_i;
  size_t data_size_i;
  logic  data_write_i;
  word_t data_rdata_o;
  logic  data_busy_o;
  logic  data_err_o;
  logic  fetch_req_i;
  addr_t fetch_pc_i;
  word_t fetch_instr_o;
  logic  fetch_valid_o;
  logic  fetch_err_o;
  logic  fetch_busy_o;

  int unsigned err_cnt = 0;
  int unsigned cycle_cnt = 0;

  // Reference memory with one entry per byte address
  logic [7:0] model_mem [4*RAM_WORDS];

  wb_clock_gen u_clk_gen (
    .clk_o    (clk_i),
    .arst_n_o (arst_n_i)
  );

  wb_mem_subsystem UUT (.*);

  function automatic logic is_mapped(input addr_t addr);
    return (addr >= RAM_BASE) && (addr < MAP_END);
  endfunction

  // Code 3 counts as a byte
  function automatic int size_bytes(input size_t size);
    return (size == SIZE_WORD) ? 4 : (size == SIZE_HALF) ? 2 : 1;
  endfunction

  // Low bits below the size are ignored
  // Byte k of a word sits in lane k
  function automatic word_t model_read(input addr_t addr, input size_t size);
    word_t value;
    addr_t base;
    value = '0;
    base  = (addr - RAM_BASE) & ~(addr_t'(size_bytes(size) - 1));
    for (int i = 0; i < size_bytes(size); i++) begin
      value[8*i +: 8] = model_mem[base + i];
    end
    return value;
  endfunction

  function automatic void model_write(input addr_t addr, input size_t size, input word_t wdata);
    addr_t base;
    base = (addr - RAM_BASE) & ~(addr_t'(size_bytes(size) - 1));
    for (int i = 0; i < size_bytes(size); i++) begin
      model_mem[base + i] = wdata[8*i +: 8];
    end
  endfunction

  // Every address bit feeds the preload word
  function automatic word_t fill_word(input addr_t addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A3C_96E1;
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Load/store access or fetch or both requested on the same edge
  task automatic bus_access(input logic do_lsu, input addr_t addr, input size_t size,
                            input logic write, input word_t wdata,
                            input logic do_fetch, input addr_t pc);
    logic got_valid;
    logic got_err;
    int   waited;
    got_valid = 1'b0;
    got_err   = 1'b0;
    waited    = 0;
    @(negedge clk_i);
    data_req_i   = do_lsu;
    data_addr_i  = addr;
    data_size_i  = size;
    data_write_i = write;
    data_wdata_i = wdata;
    fetch_req_i  = do_fetch;
    fetch_pc_i   = pc;
    @(negedge clk_i);
    data_req_i  = 1'b0;
    fetch_req_i = 1'b0;
    // Busy falling ends the load/store and a one-cycle pulse ends the fetch
    while (waited < WAIT_LIMIT) begin
      got_valid |= fetch_valid_o;
      got_err   |= fetch_err_o;
      if (!(do_lsu && data_busy_o) && !(do_fetch && !got_valid && !got_err)) begin
        break;
      end
      @(negedge clk_i);
      waited++;
    end
    assert (waited < WAIT_LIMIT) else begin
      $display("Access not finished within %0d cycles at %0d ns", WAIT_LIMIT, $time);
      err_cnt++;
    end
    // Load/store goes first as it wins the bus when the grant rests on it
    if (do_lsu) begin
      check_value("data_err_o", data_err_o, !is_mapped(addr));
      if (is_mapped(addr) && write) begin
        model_write(addr, size, wdata);
      end else if (is_mapped(addr)) begin
        check_value("data_rdata_o", data_rdata_o, model_read(addr, size));
      end
    end
    if (do_fetch) begin
      check_value("fetch_valid_o", got_valid, is_mapped(pc));
      check_value("fetch_err_o", got_err, !is_mapped(pc));
      if (is_mapped(pc)) begin
        check_value("fetch_instr_o", fetch_instr_o, model_read(pc, SIZE_WORD));
      end
    end
  endtask

  task automatic lsu_access(input addr_t addr, input size_t size, input logic write,
                            input word_t wdata);
    bus_access(1'b1, addr, size, write, wdata, 1'b0, '0);
  endtask

  task automatic preload_window();
    for (int w = 0; w < WINDOW_WORDS; w++) begin
      lsu_access(RAM_BASE + 4 * w, SIZE_WORD, 1'b1, fill_word(RAM_BASE + 4 * w));
    end
  endtask

  task automatic test_word_rw();
    addr_t addr;
    for (int i = 0; i < 6; i++) begin
      // Spread over the map with the top word last
      addr = (i == 5) ? MAP_END - 4 : RAM_BASE + 32'h0A0 * i;
      lsu_access(addr, SIZE_WORD, 1'b1, $urandom);
      lsu_access(addr, SIZE_WORD, 1'b0, '0);
    end
  endtask

  task automatic test_lanes();
    for (int ws = 0; ws < 2; ws++) begin
      // Byte writes on the first pass and half-words on the second
      for (int off = 0; off < 4; off++) begin
        lsu_access(RAM_BASE + 32'h40 + off, size_t'(ws), 1'b1, $urandom);
      end
      for (int rs = 0; rs < 4; rs++) begin
        for (int off = 0; off < 4; off++) begin
          lsu_access(RAM_BASE + 32'h40 + off, size_t'(rs), 1'b0, '0);
        end
      end
    end
  endtask

  task automatic test_unmapped();
    // The RAM row aliased by this write must keep its old word
    lsu_access(MAP_END + 8, SIZE_WORD, 1'b1, 32'hDEAD_BEEF);
    lsu_access(RAM_BASE + 8, SIZE_WORD, 1'b0, '0);
    lsu_access(32'hFFFF_FFF0, SIZE_BYTE, 1'b0, '0);
    bus_access(1'b0, '0, SIZE_WORD, 1'b0, '0, 1'b1, MAP_END + 32'h40);
    lsu_access(RAM_BASE + 12, SIZE_HALF, 1'b0, '0);
  endtask

  task automatic test_contention();
    bus_access(1'b1, RAM_BASE + 32'h20, SIZE_WORD, 1'b1, $urandom, 1'b1, RAM_BASE + 32'h10);
    // Fetch of the word just written
    bus_access(1'b1, RAM_BASE + 32'h22, SIZE_HALF, 1'b0, '0, 1'b1, RAM_BASE + 32'h20);
    bus_access(1'b1, RAM_BASE + 32'h141, SIZE_BYTE, 1'b1, $urandom, 1'b1, RAM_BASE + 32'h1E0);
  endtask

  task automatic test_random();
    addr_t addr;
    size_t size;
    logic  write;
    for (int n = 0; n < 200; n++) begin
      addr  = RAM_BASE + ($urandom % (4 * WINDOW_WORDS));
      size  = size_t'($urandom % 4);
      write = ($urandom % 2) == 1;
      lsu_access(addr, size, write, $urandom);
    end
  endtask

  task automatic test_clear();
    // Flush with nothing pending drops the sticky error
    lsu_access(MAP_END, SIZE_WORD, 1'b0, '0);
    @(negedge clk_i);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    check_value("data_err_o", data_err_o, 1'b0);
    // Both masters flushed one cycle into their cycles
    data_addr_i  = RAM_BASE + 32'h44;
    data_size_i  = SIZE_WORD;
    data_write_i = 1'b0;
    data_req_i   = 1'b1;
    fetch_pc_i   = RAM_BASE + 32'h48;
    fetch_req_i  = 1'b1;
    @(negedge clk_i);
    data_req_i  = 1'b0;
    fetch_req_i = 1'b0;
    clear_i     = 1'b1;
    check_value("data_busy_o", data_busy_o, 1'b1);
    check_value("fetch_busy_o", fetch_busy_o, 1'b1);
    @(negedge clk_i);
    clear_i = 1'b0;
    check_value("data_busy_o", data_busy_o, 1'b0);
    check_value("fetch_busy_o", fetch_busy_o, 1'b0);
    bus_access(1'b1, RAM_BASE + 32'h46, SIZE_HALF, 1'b1, $urandom, 1'b1, RAM_BASE + 32'h48);
    lsu_access(RAM_BASE + 32'h44, SIZE_WORD, 1'b0, '0);
  endtask

  // Watchdog on total run length
  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout, run stopped after %0d cycles with %0d error(s)", cycle_cnt, err_cnt);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(57993));
    clear_i      = 1'b0;
    data_req_i   = 1'b0;
    data_addr_i  = '0;
    data_wdata_i = '0;
    data_size_i  = SIZE_WORD;
    data_write_i = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_pc_i   = '0;
    wait (arst_n_i === 1'b1);
    @(negedge clk_i);
    check_value("data_busy_o", data_busy_o, 1'b0);
    check_value("data_err_o", data_err_o, 1'b0);
    check_value("fetch_busy_o", fetch_busy_o, 1'b0);
    check_value("fetch_valid_o", fetch_valid_o, 1'b0);
    check_value("fetch_err_o", fetch_err_o, 1'b0);
    preload_window();
    test_word_rw();
    test_lanes();
    test_unmapped();
    test_contention();
    test_random();
    test_clear();
    $display("Done after %0d cycles, %0d error(s)", cycle_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* wb_mem_subsystem.f */
rtl/wb_pkg.sv
rtl/wb_lsu_master.sv
rtl/wb_fetch_master.sv
rtl/wb_arbiter.sv
rtl/wb_addr_decoder.sv
rtl/wb_ram.sv
rtl/wb_mem_subsystem.sv
test/wb_clock_gen.sv
test/wb_mem_subsystem_props.sv
test/wb_mem_subsystem_tb.sv
